//--- src/wb_soc_pkg.sv
//--------------------
// Pipelined Wishbone with 32-bit byte addresses and 32-bit data
// Address windows are inclusive and must not overlap within one router
//--------------------
package wb_soc_pkg;

	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;
	typedef logic [11:0] wb_ofs_t;

	// Master side of a link
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
	} wb_req_t;

	// Slave side of a link
	typedef struct packed {
		logic    stall;
		logic    ack;
		logic    err;
		wb_dat_t dat;
	} wb_rsp_t;

	//--------------------
	// Address map
	//--------------------
	localparam wb_adr_t IO_BASE   = 32'h0000_0000;
	localparam wb_adr_t IO_LAST   = 32'h0000_2FFF;
	localparam wb_adr_t RAM_BASE  = 32'h0010_0000;
	localparam wb_adr_t RAM_LAST  = 32'h0010_0FFF;
	localparam wb_adr_t ROM_BASE  = 32'h0000_0000;
	localparam wb_adr_t ROM_LAST  = 32'h0000_0FFF;
	localparam wb_adr_t GPIO_BASE = 32'h0000_1000;
	localparam wb_adr_t GPIO_LAST = 32'h0000_2FFF;

	// GPIO register offsets
	localparam wb_ofs_t GPIO_OUT_OFS = 12'h000;
	localparam wb_ofs_t GPIO_EN_OFS  = 12'h004;
	localparam wb_ofs_t GPIO_IN_OFS  = 12'h008;

	// Upper half of every ROM word
	localparam logic [15:0] ROM_TAG = 16'hC0DE;

endpackage

//--- src/wb_addr_router.sv
//--------------------
// One transfer in flight, stall is held for the response cycle
// A miss in both windows is answered with err by the router
//--------------------
`timescale 1ns/10ps

module wb_addr_router
	import wb_soc_pkg::*;
#(
	parameter wb_adr_t S0_BASE = 32'h0000_0000,
	parameter wb_adr_t S0_LAST = 32'h0000_0FFF,
	parameter wb_adr_t S1_BASE = 32'h0000_1000,
	parameter wb_adr_t S1_LAST = 32'h0000_1FFF
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t m_req_i,
	output wb_rsp_t m_rsp_o,
	output wb_req_t s0_req_o,
	output wb_req_t s1_req_o,
	input  wb_rsp_t s0_rsp_i,
	input  wb_rsp_t s1_rsp_i
);

	typedef enum logic [1:0] {
		TGT_IDLE,
		TGT_S0,
		TGT_S1,
		TGT_MISS
	} tgt_e;

	tgt_e tgt_q;
	logic hit0;
	logic hit1;
	logic busy;
	logic stall;
	logic acc;

	// Window s0 wins if the two overlap
	assign hit0 = (m_req_i.adr >= S0_BASE) && (m_req_i.adr <= S0_LAST);
	assign hit1 = !hit0 && (m_req_i.adr >= S1_BASE) && (m_req_i.adr <= S1_LAST);

	assign busy  = (tgt_q != TGT_IDLE);
	assign stall = busy | (hit0 & s0_rsp_i.stall) | (hit1 & s1_rsp_i.stall);
	assign acc   = m_req_i.cyc & m_req_i.stb & ~stall;

	//--------------------
	// Request forwarding
	//--------------------
	always_comb begin
		s0_req_o     = m_req_i;
		s0_req_o.cyc = m_req_i.cyc & hit0;
		s0_req_o.stb = m_req_i.stb & hit0 & ~busy;
		s1_req_o     = m_req_i;
		s1_req_o.cyc = m_req_i.cyc & hit1;
		s1_req_o.stb = m_req_i.stb & hit1 & ~busy;
	end

	// Target of the transfer now in its response cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tgt_q <= TGT_IDLE;
		end else if (acc) begin
			if (hit0)
				tgt_q <= TGT_S0;
			else if (hit1)
				tgt_q <= TGT_S1;
			else
				tgt_q <= TGT_MISS;
		end else begin
			tgt_q <= TGT_IDLE;
		end
	end

	//--------------------
	// Response return
	//--------------------
	always_comb begin
		m_rsp_o       = '0;
		m_rsp_o.stall = stall;
		case (tgt_q)
			TGT_S0: begin
				m_rsp_o.ack = s0_rsp_i.ack;
				m_rsp_o.err = s0_rsp_i.err;
				m_rsp_o.dat = s0_rsp_i.dat;
			end
			TGT_S1: begin
				m_rsp_o.ack = s1_rsp_i.ack;
				m_rsp_o.err = s1_rsp_i.err;
				m_rsp_o.dat = s1_rsp_i.dat;
			end
			TGT_MISS: begin
				m_rsp_o.err = 1'b1;
			end
			default: begin
				m_rsp_o.ack = 1'b0;
			end
		endcase
	end

endmodule

//--- src/wb_ram.sv
//--------------------
// Word index is the word address modulo RAM_WORDS, contents start unknown
//--------------------
`timescale 1ns/10ps

module wb_ram
	import wb_soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int LANES = $bits(wb_sel_t);

	typedef logic [IDX_W-1:0] ram_idx_t;

	wb_dat_t  mem [RAM_WORDS];
	wb_dat_t  dat_q;
	logic     ack_q;
	logic     acc;
	ram_idx_t idx;

	assign acc = req_i.cyc & req_i.stb;
	assign idx = ram_idx_t'((req_i.adr >> 2) % RAM_WORDS);

	// Byte lanes under sel, read word registered
	always_ff @(posedge clk) begin
		if (acc) begin
			if (req_i.we) begin
				for (int b = 0; b < LANES; b++) begin
					if (req_i.sel[b])
						mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
				end
			end else begin
				dat_q <= mem[idx];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= acc;
	end

	assign rsp_o = '{stall: 1'b0, ack: ack_q, err: 1'b0, dat: dat_q};

endmodule

//--- src/wb_rom.sv
//--------------------
// Contents are computed, writes answer err and change nothing
//--------------------
`timescale 1ns/10ps

module wb_rom
	import wb_soc_pkg::*;
#(
	parameter int ROM_WORDS = 64
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	wb_dat_t     dat_q;
	logic        ack_q;
	logic        err_q;
	logic        acc;
	logic [15:0] idx;

	assign acc = req_i.cyc & req_i.stb;
	assign idx = 16'((req_i.adr >> 2) % ROM_WORDS);

	// Tag in the upper half, word index in the lower half
	always_ff @(posedge clk) begin
		if (acc && !req_i.we)
			dat_q <= {ROM_TAG, idx};
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= acc & ~req_i.we;
			err_q <= acc & req_i.we;
		end
	end

	assign rsp_o = '{stall: 1'b0, ack: ack_q, err: err_q, dat: dat_q};

endmodule

//--- src/wb_gpio.sv
//--------------------
// Byte selects are ignored, GPIO_W is at most 32
// Input register is the second synchroniser flop
//--------------------
`timescale 1ns/10ps

module wb_gpio
	import wb_soc_pkg::*;
#(
	parameter int GPIO_W = 8
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  wb_req_t           req_i,
	output wb_rsp_t           rsp_o,
	output logic [GPIO_W-1:0] gpio_o,
	output logic [GPIO_W-1:0] gpio_en_o,
	input  logic [GPIO_W-1:0] gpio_i
);

	typedef logic [GPIO_W-1:0] gpio_vec_t;

	gpio_vec_t out_q;
	gpio_vec_t en_q;
	gpio_vec_t sync1_q;
	gpio_vec_t sync2_q;
	wb_dat_t   dat_q;
	wb_dat_t   rd_dat;
	wb_ofs_t   ofs;
	logic      ack_q;
	logic      err_q;
	logic      acc;
	logic      bad;

	assign acc = req_i.cyc & req_i.stb;
	assign ofs = req_i.adr[$bits(wb_ofs_t)-1:0];

	//--------------------
	// Register decode
	//--------------------
	always_comb begin
		rd_dat = '0;
		bad    = 1'b0;
		case (ofs)
			GPIO_OUT_OFS: rd_dat = wb_dat_t'(out_q);
			GPIO_EN_OFS:  rd_dat = wb_dat_t'(en_q);
			GPIO_IN_OFS: begin
				rd_dat = wb_dat_t'(sync2_q);
				bad    = req_i.we;
			end
			default: bad = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_q   <= '0;
			en_q    <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
			ack_q   <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			ack_q   <= acc & ~bad;
			err_q   <= acc & bad;
			if (acc && req_i.we && ofs == GPIO_OUT_OFS)
				out_q <= req_i.dat[GPIO_W-1:0];
			if (acc && req_i.we && ofs == GPIO_EN_OFS)
				en_q <= req_i.dat[GPIO_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc && !req_i.we)
			dat_q <= rd_dat;
	end

	assign rsp_o     = '{stall: 1'b0, ack: ack_q, err: err_q, dat: dat_q};
	assign gpio_o    = out_q;
	assign gpio_en_o = en_q;

endmodule

//--- src/wb_soc_top.sv
//--------------------
// Single master, every response one cycle after acceptance
//--------------------
`timescale 1ns/10ps

module wb_soc_top
	import wb_soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024,
	parameter int ROM_WORDS = 64,
	parameter int GPIO_W    = 8
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  wb_req_t           cpu_req_i,
	output wb_rsp_t           cpu_rsp_o,
	output logic [GPIO_W-1:0] gpio_o,
	output logic [GPIO_W-1:0] gpio_en_o,
	input  logic [GPIO_W-1:0] gpio_i
);

	wb_req_t io_req;
	wb_rsp_t io_rsp;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	wb_req_t rom_req;
	wb_rsp_t rom_rsp;
	wb_req_t gpio_req;
	wb_rsp_t gpio_rsp;

	//--------------------
	// Top level decode
	//--------------------
	wb_addr_router #(
		.S0_BASE (IO_BASE),
		.S0_LAST (IO_LAST),
		.S1_BASE (RAM_BASE),
		.S1_LAST (RAM_LAST)
	) bus_router (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.m_req_i  (cpu_req_i),
		.m_rsp_o  (cpu_rsp_o),
		.s0_req_o (io_req),
		.s1_req_o (ram_req),
		.s0_rsp_i (io_rsp),
		.s1_rsp_i (ram_rsp)
	);

	wb_ram #(.RAM_WORDS(RAM_WORDS)) ram_inst_mem (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	// I/O space
	wb_addr_router #(
		.S0_BASE (ROM_BASE),
		.S0_LAST (ROM_LAST),
		.S1_BASE (GPIO_BASE),
		.S1_LAST (GPIO_LAST)
	) io_router (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.m_req_i  (io_req),
		.m_rsp_o  (io_rsp),
		.s0_req_o (rom_req),
		.s1_req_o (gpio_req),
		.s0_rsp_i (rom_rsp),
		.s1_rsp_i (gpio_rsp)
	);

	wb_rom #(.ROM_WORDS(ROM_WORDS)) boot_rom (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (rom_req),
		.rsp_o   (rom_rsp)
	);

	wb_gpio #(.GPIO_W(GPIO_W)) gpio_regs (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.req_i     (gpio_req),
		.rsp_o     (gpio_rsp),
		.gpio_o    (gpio_o),
		.gpio_en_o (gpio_en_o),
		.gpio_i    (gpio_i)
	);

endmodule

//--- test/wb_soc_asserts.sv
//--------------------
// Master-side handshake rules, one transfer in flight
//--------------------
`timescale 1ns/10ps

module wb_soc_asserts
	import wb_soc_pkg::*;
(
	input logic    clk,
	input logic    rst_n_i,
	input wb_req_t req_i,
	input wb_rsp_t rsp_i
);

	logic acc;
	logic rsp;

	assign acc = req_i.cyc & req_i.stb & ~rsp_i.stall;
	assign rsp = rsp_i.ack | rsp_i.err;

	ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(rsp_i.ack && rsp_i.err))
		else $error("ack and err high in the same cycle");

	// One response, one cycle after acceptance
	rsp_after_acc: assert property (@(posedge clk) disable iff (!rst_n_i)
		acc |=> rsp)
		else $error("no response in the cycle after acceptance");

	no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp |-> $past(acc))
		else $error("response without an accepted transfer");

	stall_in_rsp: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_i.stall == $past(acc))
		else $error("stall not confined to the response cycle");

endmodule

//--- test/tb_wb_soc.sv
//--------------------
// Random single-master transfers checked against a reference model
// RAM bytes never written are masked out of read checks
//--------------------
`timescale 1ns/10ps

module tb_wb_soc
	import wb_soc_pkg::*;
#(
	parameter int SEED = 37477
);

	localparam int RAM_WORDS = 1024;
	localparam int ROM_WORDS = 64;
	localparam int GPIO_W    = 8;
	localparam int N_XFER    = 400;
	// At most five cycles per transfer, with margin
	localparam int TIMEOUT   = 8 * N_XFER + 100;

	typedef logic [GPIO_W-1:0] gpio_vec_t;
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

	logic      clk = 1'b0;
	logic      rst_n;
	wb_req_t   cpu_req;
	wb_rsp_t   cpu_rsp;
	gpio_vec_t gpio_out;
	gpio_vec_t gpio_en;
	gpio_vec_t gpio_in;

	// Reference model
	wb_dat_t   ram_model [RAM_WORDS];
	wb_sel_t   ram_known [RAM_WORDS];
	gpio_vec_t out_model;
	gpio_vec_t en_model;
	gpio_vec_t in_d1;
	gpio_vec_t in_d2;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;

	wb_soc_top #(
		.RAM_WORDS (RAM_WORDS),
		.ROM_WORDS (ROM_WORDS),
		.GPIO_W    (GPIO_W)
	) wb_soc_top_inst (
		.clk       (clk),
		.rst_n_i   (rst_n),
		.cpu_req_i (cpu_req),
		.cpu_rsp_o (cpu_rsp),
		.gpio_o    (gpio_out),
		.gpio_en_o (gpio_en),
		.gpio_i    (gpio_in)
	);

	bind wb_soc_top wb_soc_asserts asserts_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (cpu_req_i),
		.rsp_i   (cpu_rsp_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: transfers not finished after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// gpio_i as sampled one and two edges back
	always @(posedge clk) begin
		in_d1 <= gpio_in;
		in_d2 <= in_d1;
	end

	function automatic wb_dat_t lane_mask(input wb_sel_t sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	task automatic check_value(input string name, input wb_dat_t act, input wb_dat_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s = %h, expected %h at %0t", name, act, exp, $time);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		gpio_in <= gpio_vec_t'($random(seed));
	endtask

	task automatic idle_cycle();
		tick();
		@(negedge clk);
		check_value("cpu_rsp_o.stall", wb_dat_t'(cpu_rsp.stall), '0);
		check_value("cpu_rsp_o.ack", wb_dat_t'(cpu_rsp.ack), '0);
		check_value("cpu_rsp_o.err", wb_dat_t'(cpu_rsp.err), '0);
	endtask

	task automatic run_transfer(input wb_req_t req, input logic exp_err, input wb_dat_t exp_dat,
		input wb_dat_t dat_mask, input logic in_read);
		wb_dat_t expect_dat;
		expect_dat = exp_dat;
		tick();
		cpu_req <= req;
		@(negedge clk);
		check_value("cpu_rsp_o.ack", wb_dat_t'(cpu_rsp.ack), '0);
		check_value("cpu_rsp_o.err", wb_dat_t'(cpu_rsp.err), '0);
		while (cpu_rsp.stall) begin
			tick();
			@(negedge clk);
		end
		// Acceptance edge
		tick();
		if (in_read)
			expect_dat = wb_dat_t'(in_d2);
		cpu_req <= '0;
		@(negedge clk);
		check_value("cpu_rsp_o.stall", wb_dat_t'(cpu_rsp.stall), 32'h1);
		check_value("cpu_rsp_o.ack", wb_dat_t'(cpu_rsp.ack), wb_dat_t'(!exp_err));
		check_value("cpu_rsp_o.err", wb_dat_t'(cpu_rsp.err), wb_dat_t'(exp_err));
		if (!req.we && !exp_err)
			check_value("cpu_rsp_o.dat", cpu_rsp.dat & dat_mask, expect_dat & dat_mask);
	endtask

	initial begin
		wb_req_t  req;
		wb_dat_t  exp_dat;
		wb_dat_t  mask;
		wb_ofs_t  ofs;
		ram_idx_t idx;
		int       kind;
		int       word;
		logic     exp_err;
		logic     in_read;

		seed      = SEED;
		rst_n     = 1'b0;
		cpu_req   = '0;
		gpio_in   = '0;
		out_model = '0;
		en_model  = '0;
		ram_known = '{default: '0};
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// State right after reset
		@(negedge clk);
		check_value("cpu_rsp_o.stall", wb_dat_t'(cpu_rsp.stall), '0);
		check_value("cpu_rsp_o.ack", wb_dat_t'(cpu_rsp.ack), '0);
		check_value("cpu_rsp_o.err", wb_dat_t'(cpu_rsp.err), '0);
		check_value("gpio_o", wb_dat_t'(gpio_out), '0);
		check_value("gpio_en_o", wb_dat_t'(gpio_en), '0);
		repeat (3) idle_cycle();

		for (int n = 0; n < N_XFER; n++) begin
			kind    = $random(seed) & 15;
			req.cyc = 1'b1;
			req.stb = 1'b1;
			req.we  = 1'($random(seed));
			req.dat = wb_dat_t'($random(seed));
			req.sel = wb_sel_t'($random(seed));
			exp_err = 1'b0;
			exp_dat = '0;
			mask    = '1;
			in_read = 1'b0;
			if (kind < 7) begin
				// RAM, 32 words spread over the window
				word    = ($random(seed) & 31) * 31;
				req.adr = RAM_BASE + wb_adr_t'(word * 4);
				idx     = ram_idx_t'(word % RAM_WORDS);
				exp_dat = ram_model[idx];
				mask    = lane_mask(ram_known[idx]);
			end else if (kind < 10) begin
				word    = $random(seed) & 1023;
				req.adr = ROM_BASE + wb_adr_t'(word * 4);
				exp_err = req.we;
				exp_dat = {16'hC0DE, 16'(word % ROM_WORDS)};
			end else if (kind < 14) begin
				// Both aliases of the GPIO window, offset 0xC is undefined
				ofs     = wb_ofs_t'(($random(seed) & 3) * 4);
				req.adr = ((($random(seed) & 1) != 0) ? 32'h0000_2000 : GPIO_BASE);
				req.adr = req.adr + wb_adr_t'(ofs);
				case (ofs)
					GPIO_OUT_OFS: exp_dat = wb_dat_t'(out_model);
					GPIO_EN_OFS:  exp_dat = wb_dat_t'(en_model);
					GPIO_IN_OFS: begin
						in_read = !req.we;
						exp_err = req.we;
					end
					default: exp_err = 1'b1;
				endcase
			end else begin
				case ($random(seed) & 3)
					0: req.adr = 32'h0000_3000 + (wb_adr_t'($random(seed)) & 32'h0000_0FFC);
					1: req.adr = 32'h0020_0000;
					2: req.adr = RAM_LAST + 32'h1;
					default: req.adr = 32'hFFFF_FFFC;
				endcase
				exp_err = 1'b1;
			end

			run_transfer(req, exp_err, exp_dat, mask, in_read);

			if (req.we && !exp_err) begin
				if (kind < 7) begin
					mask           = lane_mask(req.sel);
					ram_model[idx] = (ram_model[idx] & ~mask) | (req.dat & mask);
					ram_known[idx] = ram_known[idx] | req.sel;
				end else if (ofs == GPIO_OUT_OFS) begin
					out_model = gpio_vec_t'(req.dat);
				end else if (ofs == GPIO_EN_OFS) begin
					en_model = gpio_vec_t'(req.dat);
				end
			end
			check_value("gpio_o", wb_dat_t'(gpio_out), wb_dat_t'(out_model));
			check_value("gpio_en_o", wb_dat_t'(gpio_en), wb_dat_t'(en_model));
			repeat ($random(seed) & 3) idle_cycle();
		end

		idle_cycle();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- tb.f
src/wb_soc_pkg.sv
src/wb_addr_router.sv
src/wb_ram.sv
src/wb_rom.sv
src/wb_gpio.sv
src/wb_soc_top.sv
test/wb_soc_asserts.sv
test/tb_wb_soc.sv

//--- Makefile
# Verilator build and run of the Wishbone SoC testbench

SIM       ?= verilator
TOP       ?= tb_wb_soc
SEED      ?= 37477
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
